/* Bender.yml */
package:
  name: hubCore

sources:
  - hubPkg.sv
  - hubSequencer.sv
  - ethRegArbiter.sv
  - hubRam.sv
  - hubCore.sv
  - target: test
    files:
      - hubCoreTb.sv

/* ethRegArbiter.sv */
/* ethernet register bus arbiter
   owner decode, request mux, ack routing and ram port B select */

module ethRegArbiter import hubPkg::*; (
	input  hubPhaseT            phase,
	input  regWbReqT            initReq,
	input  regWbReqT            transReq,
	input  regWbReqT            recvReq,
	input  logic                regAck,
	input  logic [ramAddrW-1:0] initRamAdr,
	input  logic [ramAddrW-1:0] transRamAdr,
	input  logic [ramAddrW-1:0] recvRamAdr,
	input  logic                recvRamWe,
	output regWbReqT            regReq,
	output logic                initAck,
	output logic                transAck,
	output logic                recvAck,
	output logic [ramAddrW-1:0] ramBAdr,
	output logic                ramBWe
);

	regOwnerT owner;

	// owner from the sequencer phase
	always_comb begin
		case (phase)
			phUninit:                   owner = ownInit;
			phEthTransPc, phEthTransBc: owner = ownTrans;
			phEthRecv:                  owner = ownRecv;
			// firewire phases leave the port alone
			default:                    owner = ownIdle;
		endcase
	end

	// --------------------------------------------------
	// request and ram address select
	// --------------------------------------------------

	always_comb begin
		case (owner)
			ownInit: begin
				regReq  = initReq;
				ramBAdr = initRamAdr;
			end
			ownTrans: begin
				regReq  = transReq;
				ramBAdr = transRamAdr;
			end
			ownRecv: begin
				regReq  = recvReq;
				ramBAdr = recvRamAdr;
			end
			// no cycle on the bus
			default: begin
				regReq  = '0;
				ramBAdr = '0;
			end
		endcase
	end

	// ack only to the owner
	assign initAck  = regAck && (owner == ownInit);
	assign transAck = regAck && (owner == ownTrans);
	assign recvAck  = regAck && (owner == ownRecv);

	// receive engine fills the ram only while it owns the port
	assign ramBWe = recvRamWe && (owner == ownRecv);

endmodule

/* hubCore.f */
hubPkg.sv
hubSequencer.sv
ethRegArbiter.sv
hubRam.sv
hubCore.sv
hubCoreTb.sv

/* hubCore.sv */
/* top level of the hub control core
   sequencer, register bus arbiter and hub ram */

module hubCore import hubPkg::*; (
	input  logic                  sysclk,
	input  logic                  RSTN,
	// link engine events
	input  linkEventT             events,
	input  logic [nodeCountW-1:0] numNode,
	output hubPhaseT              phase,
	// ethernet register bus
	input  regWbReqT              initReq,
	input  regWbReqT              transReq,
	input  regWbReqT              recvReq,
	input  logic                  regAck,
	output regWbReqT              regReq,
	output logic                  initAck,
	output logic                  transAck,
	output logic                  recvAck,
	// ethernet side of the ram
	input  logic [ramAddrW-1:0]   initRamAdr,
	input  logic [ramAddrW-1:0]   transRamAdr,
	input  logic [ramAddrW-1:0]   recvRamAdr,
	input  logic                  recvRamWe,
	input  logic [ramDataW-1:0]   recvRamWdat,
	output logic [ramDataW-1:0]   ramBRdat,
	// firewire side of the ram
	input  ramWbReqT              ramAReq,
	output logic                  ramAAck,
	output logic [ramDataW-1:0]   ramARdat
);

	logic [ramAddrW-1:0] ramBAdr;
	logic                ramBWe;

	// --------------------------------------------------
	// procedural control
	// --------------------------------------------------

	hubSequencer i_hubSequencer (
		.sysclk  (sysclk),
		.RSTN    (RSTN),
		.events  (events),
		.numNode (numNode),
		.phase   (phase)
	);

	// register port and ram port B follow the phase
	ethRegArbiter i_ethRegArbiter (
		.phase       (phase),
		.initReq     (initReq),
		.transReq    (transReq),
		.recvReq     (recvReq),
		.regAck      (regAck),
		.initRamAdr  (initRamAdr),
		.transRamAdr (transRamAdr),
		.recvRamAdr  (recvRamAdr),
		.recvRamWe   (recvRamWe),
		.regReq      (regReq),
		.initAck     (initAck),
		.transAck    (transAck),
		.recvAck     (recvAck),
		.ramBAdr     (ramBAdr),
		.ramBWe      (ramBWe)
	);

	// --------------------------------------------------
	// request and response buffer
	// --------------------------------------------------

	hubRam i_hubRam (
		.sysclk   (sysclk),
		.RSTN     (RSTN),
		.ramAReq  (ramAReq),
		.ramBAdr  (ramBAdr),
		.ramBWe   (ramBWe),
		.ramBWdat (recvRamWdat),
		.ramAAck  (ramAAck),
		.ramARdat (ramARdat),
		.ramBRdat (ramBRdat)
	);

endmodule

/* hubCoreTb.sv */
/* testbench for the hub control core
   clock, lfsr, phase reference model, compare process and directed tests */

module hubCoreTb import hubPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                  sysclk = 1'b0;
	logic                  RSTN;
	linkEventT             events;
	logic [nodeCountW-1:0] numNode;
	hubPhaseT              phase;
	regWbReqT              initReq, transReq, recvReq, regReq;
	logic                  regAck, initAck, transAck, recvAck;
	logic [ramAddrW-1:0]   initRamAdr, transRamAdr, recvRamAdr;
	logic                  recvRamWe;
	logic [ramDataW-1:0]   recvRamWdat, ramBRdat, ramARdat;
	ramWbReqT              ramAReq;
	logic                  ramAAck;

	// reference state and bookkeeping
	hubPhaseT            refPhase = phUninit;
	int                  refTimer = 0;
	int                  refBcSeen = 0;
	int                  phaseErrors = 0;
	int                  checkErrors = 0;
	int                  timeoutErrors = 0;
	string               testName = "reset";
	logic [31:0]         lfsrState = 32'h7826_3e6b;
	logic [ramDataW-1:0] memCopy [2**ramAddrW];
	logic [ramAddrW-1:0] addrList [8];

	hubCore i_hubCore (.*);

	// 100 ns period
	always #50 sysclk = ~sysclk;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
	endtask

	// expected phase after one clock edge
	function automatic hubPhaseT nextPhase(input hubPhaseT cur, input linkEventT ev,
			input int bcSeen, input int nodes, input bit waitOver);
		hubPhaseT nxt;
		nxt = cur;
		case (cur)
			phUninit: if (ev.initDone) nxt = phEthRecv;
			phEthRecv: begin
				if (ev.reqNew && (ev.reqType == frNormal || ev.reqType == frBcWrite))
					nxt = phFwTransPc;
				else if (ev.reqNew && ev.reqType == frBcRead)
					nxt = phFwTransBc;
			end
			phFwTransPc: begin
				if (ev.pcReqTxed)
					nxt = (ev.reqType == frNormal) ? phFwAckPc : phEthRecv;
			end
			phFwTransBc: if (ev.bcReqTxed) nxt = phFwAckBc;
			phFwAckPc: begin
				if (ev.ackRxed) nxt = (ev.ackResp == ackPend) ? phFwRecvPc : phEthRecv;
				else if (waitOver) nxt = phEthRecv;
			end
			phFwAckBc: begin
				if (ev.ackRxed) nxt = (ev.ackResp == ackDone) ? phFwRecvBc : phEthRecv;
				else if (waitOver) nxt = phEthRecv;
			end
			phFwRecvPc: begin
				if (ev.respRxed) nxt = phEthTransPc;
				else if (waitOver) nxt = phEthRecv;
			end
			// response number nodes+1 ends the broadcast read
			phFwRecvBc: if (ev.bcRespRxed && bcSeen == nodes) nxt = phEthTransBc;
			phEthTransPc, phEthTransBc: if (ev.transDone) nxt = phEthRecv;
			default: nxt = phUninit;
		endcase
		return nxt;
	endfunction

	// inputs change 5 ns after the rising edge
	task automatic nextCycle();
		@(posedge sysclk);
		#5;
	endtask

	// firewire phases also need an idle register bus
	task automatic checkPhase(input hubPhaseT expPhase);
		if (phase !== expPhase) begin
			$display("Mismatch %s: expected %s, actual %s", testName, expPhase.name(),
				phase.name());
			checkErrors++;
		end
		if (expPhase >= phFwTransPc && expPhase <= phFwRecvBc && regReq.cyc !== 1'b0) begin
			$display("%s: register bus cycle seen during a firewire phase", testName);
			checkErrors++;
		end
	endtask

	// flags in struct order from initDone down to transDone
	task automatic step(input logic [7:0] flags, input hubPhaseT expPhase);
		events[13:6] = flags;
		nextCycle();
		events[13:6] = '0;
		checkPhase(expPhase);
	endtask

	function automatic regWbReqT regRequest(input logic [7:0] adr, input logic [15:0] dat);
		regWbReqT r;
		r = '0;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = 1'b1;
		r.adr = adr;
		r.dat = dat;
		return r;
	endfunction

	// register bus owner seen through the forwarded request and the ack routing
	task automatic expectRegOwner(input regWbReqT expReq, input logic [2:0] expAcks);
		regAck = 1'b1;
		#1;
		if (regReq !== expReq) begin
			$display("Mismatch %s: expected %h, actual %h", testName, expReq, regReq);
			checkErrors++;
		end
		if ({initAck, transAck, recvAck} !== expAcks) begin
			$display("Mismatch %s: expected acks %b, actual %b", testName, expAcks,
				{initAck, transAck, recvAck});
			checkErrors++;
		end
		regAck = 1'b0;
	endtask

	// one wishbone classic access on port A
	task automatic ramAccessA(input logic we, input logic [ramAddrW-1:0] adr,
			input logic [ramDataW-1:0] dat, output logic [ramDataW-1:0] rdat);
		int waitCycles;
		ramAReq.cyc = 1'b1;
		ramAReq.stb = 1'b1;
		ramAReq.we  = we;
		ramAReq.adr = adr;
		ramAReq.dat = dat;
		waitCycles = 0;
		do begin
			nextCycle();
			waitCycles++;
		end while (!ramAAck && waitCycles < 8);
		rdat = ramARdat;
		if (!ramAAck) begin
			$display("%s: no ack from ram port A at address %0h", testName, adr);
			timeoutErrors++;
		end else if (waitCycles != 1) begin
			$display("Mismatch %s: expected ack latency 1, actual %0d", testName, waitCycles);
			checkErrors++;
		end
		ramAReq = '0;
		nextCycle();
	endtask

	// --------------------------------------------------
	// compare process
	// --------------------------------------------------

	// events are stable at the falling edge
	always @(negedge sysclk) begin
		hubPhaseT expNext;
		bit       inWait;
		if (phase !== refPhase) begin
			$display("Mismatch %s: expected %s, actual %s", testName, refPhase.name(),
				phase.name());
			phaseErrors++;
		end
		if (!RSTN) begin
			refPhase = phUninit;
			refTimer = 0;
			refBcSeen = 0;
		end else begin
			inWait = (refPhase == phFwAckPc) || (refPhase == phFwAckBc) ||
				(refPhase == phFwRecvPc);
			expNext = nextPhase(refPhase, events, refBcSeen, int'(numNode),
				inWait && (refTimer == timeoutLimit));
			// timer restarts on every entry
			if (!inWait || expNext != refPhase) refTimer = 0;
			else refTimer++;
			if (refPhase != phFwRecvBc || expNext != refPhase) refBcSeen = 0;
			else if (events.bcRespRxed) refBcSeen++;
			refPhase = expNext;
		end
	end

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	initial begin
		logic [31:0] rnd, rdat;
		int          held;
		RSTN = 1'b0;
		events = '0;
		numNode = '0;
		initReq = '0;
		transReq = '0;
		recvReq = '0;
		regAck = 1'b0;
		initRamAdr = '0;
		transRamAdr = '0;
		recvRamAdr = '0;
		recvRamWe = 1'b0;
		recvRamWdat = '0;
		ramAReq = '0;
		repeat (2) @(posedge sysclk);
		#5 RSTN = 1'b1;

		// 1. only init owns the bus before initDone
		checkPhase(phUninit);
		if (ramAAck !== 1'b0) begin
			$display("%s: ram port A ack is high after reset", testName);
			checkErrors++;
		end
		initReq = regRequest(8'h10, 16'h1111);
		transReq = regRequest(8'h20, 16'h2222);
		recvReq = regRequest(8'h30, 16'h3333);
		expectRegOwner(initReq, 3'b100);
		step(8'b1000_0000, phEthRecv);

		// 5. receive engine owns the bus while the transmit engine waits
		testName = "arbitration";
		expectRegOwner(recvReq, 3'b001);

		// 2. full normal request, then an ack of done
		testName = "normal";
		events.reqType = frNormal;
		events.ackResp = ackPend;
		step(8'b0100_0000, phFwTransPc);
		step(8'b0010_0000, phFwAckPc);
		step(8'b0000_1000, phFwRecvPc);
		step(8'b0000_0100, phEthTransPc);
		step(8'b0000_0001, phEthRecv);
		events.ackResp = ackDone;
		step(8'b0100_0000, phFwTransPc);
		step(8'b0010_0000, phFwAckPc);
		step(8'b0000_1000, phEthRecv);

		// 3. no ack at all
		testName = "timeout";
		step(8'b0100_0000, phFwTransPc);
		step(8'b0010_0000, phFwAckPc);
		held = 0;
		while (phase == phFwAckPc && held < timeoutLimit + 16) begin
			nextCycle();
			held++;
		end
		if (held != timeoutLimit + 1) begin
			$display("Mismatch %s: expected %0d cycles, actual %0d", testName,
				timeoutLimit + 1, held);
			checkErrors++;
		end
		checkPhase(phEthRecv);

		// 4. broadcast read over a random node count, then broadcast write
		testName = "broadcast";
		takeBits(nodeCountW, rnd);
		numNode = rnd[nodeCountW-1:0];
		events.reqType = frBcRead;
		events.ackResp = ackDone;
		step(8'b0100_0000, phFwTransBc);
		step(8'b0001_0000, phFwAckBc);
		step(8'b0000_1000, phFwRecvBc);
		for (int i = 0; i <= numNode; i++) begin
			step(8'b0000_0010, (i == numNode) ? phEthTransBc : phFwRecvBc);
		end
		step(8'b0000_0001, phEthRecv);
		events.reqType = frBcWrite;
		step(8'b0100_0000, phFwTransPc);
		step(8'b0010_0000, phEthRecv);

		// 6. port A writes read back over port B by the transmit engine
		testName = "ram";
		for (int i = 0; i < 8; i++) begin
			takeBits(ramAddrW, rnd);
			addrList[i] = rnd[ramAddrW-1:0];
			takeBits(ramDataW, rnd);
			memCopy[addrList[i]] = rnd;
			ramAccessA(1'b1, addrList[i], rnd, rdat);
		end
		events.reqType = frNormal;
		events.ackResp = ackPend;
		step(8'b0100_0000, phFwTransPc);
		step(8'b0010_0000, phFwAckPc);
		step(8'b0000_1000, phFwRecvPc);
		step(8'b0000_0100, phEthTransPc);
		// transmit engine now owns the register port
		expectRegOwner(transReq, 3'b010);
		for (int i = 0; i < 8; i++) begin
			transRamAdr = addrList[i];
			nextCycle();
			if (ramBRdat !== memCopy[addrList[i]]) begin
				$display("Mismatch %s: expected %h, actual %h", testName,
					memCopy[addrList[i]], ramBRdat);
				checkErrors++;
			end
		end
		step(8'b0000_0001, phEthRecv);
		// receive engine fills, firewire side reads
		for (int i = 0; i < 4; i++) begin
			takeBits(ramAddrW, rnd);
			recvRamAdr = rnd[ramAddrW-1:0];
			takeBits(ramDataW, rnd);
			recvRamWdat = rnd;
			memCopy[recvRamAdr] = rnd;
			recvRamWe = 1'b1;
			nextCycle();
			recvRamWe = 1'b0;
			ramAccessA(1'b0, recvRamAdr, '0, rdat);
			if (rdat !== memCopy[recvRamAdr]) begin
				$display("Mismatch %s: expected %h, actual %h", testName,
					memCopy[recvRamAdr], rdat);
				checkErrors++;
			end
		end

		nextCycle();
		$display("errors: phase %0d, checks %0d, timeouts %0d", phaseErrors, checkErrors,
			timeoutErrors);
		if (phaseErrors + checkErrors + timeoutErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* hubPkg.sv */
/* shared types and sizing for the hub control core
   phase, frame-type, ack-code and owner enums, link-event and wishbone structs */

package hubPkg;

	// --------------------------------------------------
	// sizing
	// --------------------------------------------------

	// hub ram is 2048 words of 32 bits
	localparam int ramAddrW = 11;
	localparam int ramDataW = 32;
	// ksz8851 register data path
	localparam int regDataW = 16;
	// last counted cycle of a node wait
	localparam logic [11:0] timeoutLimit = 12'd4095;
	// node count minus one, up to 16 nodes
	localparam int nodeCountW = 4;

	// --------------------------------------------------
	// enums
	// --------------------------------------------------

	// procedural phase of the hub
	typedef enum logic [3:0] {
		phUninit     = 4'd0,
		phEthRecv    = 4'd1,
		phFwTransPc  = 4'd2,
		phFwTransBc  = 4'd3,
		phFwAckPc    = 4'd4,
		phFwAckBc    = 4'd5,
		phFwRecvPc   = 4'd6,
		phFwRecvBc   = 4'd7,
		phEthTransPc = 4'd8,
		phEthTransBc = 4'd9
	} hubPhaseT;

	// frame type decoded from the pc request
	typedef enum logic [1:0] {
		frNormal  = 2'd0,
		frBcWrite = 2'd1,
		frBcRead  = 2'd2,
		frNumNode = 2'd3
	} frameTypeT;

	// ieee 1394 ack codes returned by a node
	typedef enum logic [3:0] {
		ackDone = 4'h1,
		ackPend = 4'h2,
		ackData = 4'hD
	} ackCodeT;

	// which engine drives the ethernet register port
	typedef enum logic [1:0] {
		ownInit  = 2'd0,
		ownTrans = 2'd1,
		ownRecv  = 2'd2,
		ownIdle  = 2'd3
	} regOwnerT;

	// --------------------------------------------------
	// structs
	// --------------------------------------------------

	// one-cycle pulses from the link engines
	typedef struct packed {
		logic      initDone;
		logic      reqNew;
		logic      pcReqTxed;
		logic      bcReqTxed;
		logic      ackRxed;
		logic      respRxed;
		logic      bcRespRxed;
		logic      transDone;
		// held from reqNew to the next reqNew
		frameTypeT reqType;
		// only meaningful with ackRxed
		ackCodeT   ackResp;
	} linkEventT;

	// wishbone request toward the ethernet register port
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [7:0]          adr;
		logic [regDataW-1:0] dat;
		// single byte access when set
		logic                byteLen;
	} regWbReqT;

	// wishbone request toward hub ram port A
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [ramAddrW-1:0] adr;
		logic [ramDataW-1:0] dat;
	} ramWbReqT;

endpackage

/* hubRam.sv */
/* hub ram of 2048 x 32 bits
   wishbone classic slave on port A, plain synchronous port B */

module hubRam import hubPkg::*; (
	input  logic                sysclk,
	input  logic                RSTN,
	input  ramWbReqT            ramAReq,
	input  logic [ramAddrW-1:0] ramBAdr,
	input  logic                ramBWe,
	input  logic [ramDataW-1:0] ramBWdat,
	output logic                ramAAck,
	output logic [ramDataW-1:0] ramARdat,
	output logic [ramDataW-1:0] ramBRdat
);

	logic [ramDataW-1:0] mem [2**ramAddrW];
	logic                aAccess;

	// new strobe seen and not yet acked
	assign aAccess = ramAReq.cyc && ramAReq.stb && !ramAAck;

	// ack one cycle after the strobe, low again after that
	always_ff @(posedge sysclk or negedge RSTN) begin
		if (!RSTN) begin
			ramAAck <= 1'b0;
		end else begin
			ramAAck <= aAccess;
		end
	end

	// --------------------------------------------------
	// memory array
	// --------------------------------------------------

	always_ff @(posedge sysclk) begin
		// port A read data lines up with the ack
		if (aAccess && ramAReq.we) begin
			mem[ramAReq.adr] <= ramAReq.dat;
		end
		ramARdat <= mem[ramAReq.adr];
		// port B reads with one cycle of latency
		if (ramBWe) begin
			mem[ramBAdr] <= ramBWdat;
		end
		ramBRdat <= mem[ramBAdr];
	end

endmodule

/* hubSequencer.sv */
/* procedural sequencer of the hub
   phase FSM, node wait timeout and broadcast response counter */

module hubSequencer import hubPkg::*; (
	input  logic                  sysclk,
	input  logic                  RSTN,
	input  linkEventT             events,
	input  logic [nodeCountW-1:0] numNode,
	output hubPhaseT              phase
);

	// --------------------------------------------------
	// wait bookkeeping
	// --------------------------------------------------

	// cycles spent in the current node wait
	logic [$bits(timeoutLimit)-1:0] waitTimer;
	// broadcast responses seen so far
	logic [nodeCountW-1:0]          bcCount;
	hubPhaseT                       phaseNext;
	logic                           waitPhase;
	logic                           timedOut;
	logic                           bcLast;

	// only these phases run the timer
	assign waitPhase = (phase == phFwAckPc) || (phase == phFwAckBc) || (phase == phFwRecvPc);
	assign timedOut = waitPhase && (waitTimer == timeoutLimit);
	// pulse numNode+1 closes the broadcast read
	assign bcLast = events.bcRespRxed && (bcCount == numNode);

	// --------------------------------------------------
	// next phase
	// --------------------------------------------------

	always_comb begin
		phaseNext = phase;
		case (phase)
			// ethernet chip init
			phUninit: begin
				if (events.initDone) begin
					phaseNext = phEthRecv;
				end
			end
			// waiting for a pc frame
			phEthRecv: begin
				if (events.reqNew) begin
					case (events.reqType)
						frNormal:  phaseNext = phFwTransPc;
						frBcWrite: phaseNext = phFwTransPc;
						frBcRead:  phaseNext = phFwTransBc;
						default:   phaseNext = phEthRecv;
					endcase
				end
			end
			// pc request out on firewire
			phFwTransPc: begin
				if (events.pcReqTxed) begin
					// broadcast write gets no ack
					phaseNext = (events.reqType == frNormal) ? phFwAckPc : phEthRecv;
				end
			end
			phFwTransBc: begin
				if (events.bcReqTxed) begin
					phaseNext = phFwAckBc;
				end
			end
			// pending means read data follows
			phFwAckPc: begin
				if (events.ackRxed) begin
					phaseNext = (events.ackResp == ackPend) ? phFwRecvPc : phEthRecv;
				end else if (timedOut) begin
					phaseNext = phEthRecv;
				end
			end
			// broadcast read is acked with done
			phFwAckBc: begin
				if (events.ackRxed) begin
					phaseNext = (events.ackResp == ackDone) ? phFwRecvBc : phEthRecv;
				end else if (timedOut) begin
					phaseNext = phEthRecv;
				end
			end
			phFwRecvPc: begin
				if (events.respRxed) begin
					phaseNext = phEthTransPc;
				end else if (timedOut) begin
					phaseNext = phEthRecv;
				end
			end
			// one response per node
			phFwRecvBc: begin
				if (bcLast) begin
					phaseNext = phEthTransBc;
				end
			end
			// response back to the pc
			phEthTransPc, phEthTransBc: begin
				if (events.transDone) begin
					phaseNext = phEthRecv;
				end
			end
			default: phaseNext = phUninit;
		endcase
	end

	// --------------------------------------------------
	// state registers
	// --------------------------------------------------

	always_ff @(posedge sysclk or negedge RSTN) begin
		if (!RSTN) begin
			phase     <= phUninit;
			waitTimer <= '0;
			bcCount   <= '0;
		end else begin
			phase <= phaseNext;
			// restart on entry to every wait
			if (!waitPhase || (phaseNext != phase)) begin
				waitTimer <= '0;
			end else begin
				waitTimer <= waitTimer + 1'b1;
			end
			// count only inside the broadcast receive phase
			if ((phase != phFwRecvBc) || bcLast) begin
				bcCount <= '0;
			end else if (events.bcRespRxed) begin
				bcCount <= bcCount + 1'b1;
			end
		end
	end

endmodule
